/* hdl/spi_bridge_pkg.sv */
`default_nettype none

package spi_bridge_pkg;

    // widths with a meaning
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  cmd_type_t;
    typedef logic [15:0] cmd_len_t;   // payload length and payload index
    typedef logic [7:0]  buf_idx_t;

    // host command codes
    localparam cmd_type_t CMD_SPI_XFER = 8'h11;
    localparam cmd_type_t CMD_SPI_CFG  = 8'h12;

    localparam byte_t UPLOAD_SRC_SPI = 8'h03;  // source tag on every upload

    localparam int BUF_DEPTH = 256;  // tx and rx buffers

    localparam byte_t CFG_HALF_DEFAULT = 8'd2;

    // sclk setup, sampled by the byte engine at start
    typedef struct packed {
        byte_t half_period;  // clk cycles per sclk half, never zero
        logic  lsb_first;
    } spi_cfg_t;

    // payload byte from the command processor
    typedef struct packed {
        byte_t    data;
        cmd_len_t index;
    } cmd_beat_t;

    typedef struct packed {
        byte_t source;
        byte_t data;
    } upload_beat_t;

endpackage

`default_nettype wire

/* hdl/spi_byte_master.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_byte_master (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_start,
    input  wire spi_bridge_pkg::byte_t    i_tx_byte,
    input  wire spi_bridge_pkg::spi_cfg_t i_cfg,
    input  wire                       i_spi_miso,
    output spi_bridge_pkg::byte_t     o_rx_byte,
    output logic                      o_done,
    output logic                      o_busy,
    output logic                      o_spi_clk,
    output logic                      o_spi_cs_n,
    output logic                      o_spi_mosi
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_FINISH
    } state_t;

    state_t                   state;
    spi_bridge_pkg::byte_t    half_cnt;
    logic [2:0]               bit_cnt;
    logic                     sclk_q;
    logic                     cs_n_q;
    logic                     mosi_q;
    logic                     done_q;
    spi_bridge_pkg::spi_cfg_t cfg_q;   // held for the whole byte
    spi_bridge_pkg::byte_t    tx_sr;
    spi_bridge_pkg::byte_t    rx_sr;
    logic                     half_end;
    logic                     next_bit;

    assign half_end = (half_cnt == cfg_q.half_period - 8'd1);
    // bit that follows the current one on mosi
    assign next_bit = cfg_q.lsb_first ? tx_sr[1] : tx_sr[6];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            half_cnt <= '0;
            bit_cnt  <= '0;
            sclk_q   <= 1'b0;
            cs_n_q   <= 1'b1;
            mosi_q   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state    <= ST_SHIFT;
                        cs_n_q   <= 1'b0;
                        half_cnt <= '0;
                        bit_cnt  <= '0;
                        mosi_q   <= i_cfg.lsb_first ? i_tx_byte[0] : i_tx_byte[7];
                    end
                end
                ST_SHIFT: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        sclk_q   <= ~sclk_q;
                        if (sclk_q) begin  // falling edge
                            if (bit_cnt == 3'd7) begin
                                state <= ST_FINISH;
                            end else begin
                                bit_cnt <= bit_cnt + 3'd1;
                                mosi_q  <= next_bit;
                            end
                        end
                    end else begin
                        half_cnt <= half_cnt + 8'd1;
                    end
                end
                ST_FINISH: begin
                    // one more low half before releasing cs
                    if (half_end) begin
                        state    <= ST_IDLE;
                        cs_n_q   <= 1'b1;
                        done_q   <= 1'b1;
                        half_cnt <= '0;
                    end else begin
                        half_cnt <= half_cnt + 8'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_start) begin
            cfg_q <= i_cfg;
            tx_sr <= i_tx_byte;
        end else if (state == ST_SHIFT && half_end) begin
            if (!sclk_q) begin  // rising, sample miso
                rx_sr <= cfg_q.lsb_first ? {i_spi_miso, rx_sr[7:1]} : {rx_sr[6:0], i_spi_miso};
            end else begin
                tx_sr <= cfg_q.lsb_first ? {1'b0, tx_sr[7:1]} : {tx_sr[6:0], 1'b0};
            end
        end
    end

    assign o_rx_byte  = rx_sr;
    assign o_done     = done_q;
    assign o_busy     = (state != ST_IDLE);
    assign o_spi_clk  = sclk_q;
    assign o_spi_cs_n = cs_n_q;
    assign o_spi_mosi = mosi_q;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        i_start |-> !o_busy)
        else $error("spi_byte_master start while busy");

    a_sclk_in_cs: assert property (@(posedge clk) disable iff (!rst_n)
        (o_spi_clk != $past(o_spi_clk)) |-> !o_spi_cs_n)
        else $error("spi_byte_master sclk toggled with cs_n high");

endmodule

`default_nettype wire

/* hdl/spi_cfg_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_cfg_regs (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            i_cmd_start,
    input  wire spi_bridge_pkg::cmd_type_t i_cmd_type,
    input  wire                            i_cmd_data_valid,
    input  wire spi_bridge_pkg::cmd_beat_t i_cmd_beat,
    input  wire                            i_cmd_done,
    output spi_bridge_pkg::spi_cfg_t       o_cfg
);

    logic                     is_cfg;  // current command is ours
    spi_bridge_pkg::byte_t    half_stage;
    logic                     lsb_stage;
    spi_bridge_pkg::byte_t    half_next;
    logic                     lsb_next;
    spi_bridge_pkg::spi_cfg_t cfg_q;

    // staged values including a beat arriving with done
    always_comb begin
        half_next = half_stage;
        lsb_next  = lsb_stage;
        if (is_cfg && i_cmd_data_valid) begin
            if (i_cmd_beat.index == 16'd0) half_next = i_cmd_beat.data;
            if (i_cmd_beat.index == 16'd1) lsb_next = i_cmd_beat.data[0];
        end
    end

    always_ff @(posedge clk) begin
        if (i_cmd_start) begin
            half_stage <= '0;               // zero means keep
            lsb_stage  <= cfg_q.lsb_first;
        end else if (is_cfg && i_cmd_data_valid) begin
            half_stage <= half_next;
            lsb_stage  <= lsb_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_cfg <= 1'b0;
            cfg_q  <= '{half_period: spi_bridge_pkg::CFG_HALF_DEFAULT, lsb_first: 1'b0};
        end else begin
            if (i_cmd_start) begin
                is_cfg <= (i_cmd_type == spi_bridge_pkg::CMD_SPI_CFG);
            end else if (i_cmd_done) begin
                is_cfg <= 1'b0;
            end
            if (is_cfg && i_cmd_done) begin
                if (half_next != 8'd0) cfg_q.half_period <= half_next;
                cfg_q.lsb_first <= lsb_next;
            end
        end
    end

    assign o_cfg = cfg_q;

    a_half_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        o_cfg.half_period != 8'd0)
        else $error("spi_cfg_regs half period is zero");

endmodule

`default_nettype wire

/* hdl/spi_cmd_handler.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_cmd_handler (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            i_cmd_start,
    input  wire spi_bridge_pkg::cmd_type_t i_cmd_type,
    input  wire spi_bridge_pkg::cmd_len_t  i_cmd_length,
    input  wire                            i_cmd_data_valid,
    input  wire spi_bridge_pkg::cmd_beat_t i_cmd_beat,
    input  wire                            i_cmd_done,
    input  wire                            i_upload_ready,
    input  wire spi_bridge_pkg::byte_t     i_spi_rx_byte,
    input  wire                            i_spi_done,
    output logic                           o_cmd_ready,
    output logic                           o_upload_valid,
    output spi_bridge_pkg::upload_beat_t   o_upload_beat,
    output logic                           o_spi_start,
    output spi_bridge_pkg::byte_t          o_spi_tx_byte
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COLLECT,
        ST_PARSE,
        ST_ISSUE,
        ST_WAIT_DONE,
        ST_UPLOAD
    } state_t;

    state_t                   state;
    spi_bridge_pkg::byte_t    tx_buf [spi_bridge_pkg::BUF_DEPTH];
    spi_bridge_pkg::byte_t    rx_buf [spi_bridge_pkg::BUF_DEPTH];
    spi_bridge_pkg::byte_t    write_len;
    spi_bridge_pkg::byte_t    read_len;
    spi_bridge_pkg::cmd_len_t byte_idx;   // spi byte being sent
    spi_bridge_pkg::cmd_len_t total_len;
    spi_bridge_pkg::buf_idx_t up_idx;
    spi_bridge_pkg::buf_idx_t tx_rd_idx;
    spi_bridge_pkg::buf_idx_t rx_wr_idx;
    spi_bridge_pkg::byte_t    up_data;
    spi_bridge_pkg::byte_t    tx_byte_q;
    logic                     spi_start_q;
    logic                     up_valid_q;
    logic                     xfer_accept;
    logic                     in_write;
    logic                     last_up;

    assign xfer_accept = i_cmd_start && (i_cmd_type == spi_bridge_pkg::CMD_SPI_XFER)
                         && (i_cmd_length >= 16'd2);
    assign total_len   = spi_bridge_pkg::cmd_len_t'(write_len)
                         + spi_bridge_pkg::cmd_len_t'(read_len);
    assign in_write    = (byte_idx < spi_bridge_pkg::cmd_len_t'(write_len));
    // write bytes sit after the two length bytes
    assign tx_rd_idx   = spi_bridge_pkg::buf_idx_t'(byte_idx + 16'd2);
    assign rx_wr_idx   = spi_bridge_pkg::buf_idx_t'(byte_idx
                         - spi_bridge_pkg::cmd_len_t'(write_len));
    assign last_up     = (up_idx == read_len - 8'd1);

    always_ff @(posedge clk) begin
        if (state == ST_COLLECT && i_cmd_data_valid
            && i_cmd_beat.index < spi_bridge_pkg::BUF_DEPTH) begin
            tx_buf[spi_bridge_pkg::buf_idx_t'(i_cmd_beat.index)] <= i_cmd_beat.data;
        end
    end

    // replies of the write phase are dropped
    always_ff @(posedge clk) begin
        if (state == ST_WAIT_DONE && i_spi_done && !in_write) begin
            rx_buf[rx_wr_idx] <= i_spi_rx_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_PARSE) begin
            write_len <= tx_buf[0];
            read_len  <= tx_buf[1];
        end
        if (state == ST_ISSUE) begin
            tx_byte_q <= in_write ? tx_buf[tx_rd_idx] : 8'h00;  // zero while reading
        end
        if (state == ST_UPLOAD) begin
            if (!up_valid_q) begin
                up_data <= rx_buf[up_idx];
            end else if (i_upload_ready && !last_up) begin
                up_data <= rx_buf[up_idx + 8'd1];  // next byte without a gap
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            byte_idx    <= '0;
            up_idx      <= '0;
            spi_start_q <= 1'b0;
            up_valid_q  <= 1'b0;
        end else begin
            spi_start_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (xfer_accept) state <= ST_COLLECT;
                end
                ST_COLLECT: begin
                    if (i_cmd_done) state <= ST_PARSE;
                end
                ST_PARSE: begin
                    byte_idx <= '0;
                    state    <= ST_ISSUE;
                end
                ST_ISSUE: begin
                    if (byte_idx >= total_len) begin
                        if (read_len != 8'd0) begin
                            up_idx <= '0;
                            state  <= ST_UPLOAD;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end else begin
                        spi_start_q <= 1'b1;
                        state       <= ST_WAIT_DONE;
                    end
                end
                ST_WAIT_DONE: begin
                    if (i_spi_done) begin
                        byte_idx <= byte_idx + 16'd1;
                        state    <= ST_ISSUE;
                    end
                end
                ST_UPLOAD: begin
                    if (!up_valid_q) begin
                        up_valid_q <= 1'b1;
                    end else if (i_upload_ready) begin
                        if (last_up) begin
                            up_valid_q <= 1'b0;
                            state      <= ST_IDLE;
                        end else begin
                            up_idx <= up_idx + 8'd1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign o_cmd_ready    = (state == ST_IDLE) || (state == ST_COLLECT);
    assign o_upload_valid = up_valid_q;
    assign o_upload_beat  = '{source: spi_bridge_pkg::UPLOAD_SRC_SPI, data: up_data};
    assign o_spi_start    = spi_start_q;
    assign o_spi_tx_byte  = tx_byte_q;

    a_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
        o_upload_valid && !i_upload_ready |=> o_upload_valid && $stable(o_upload_beat))
        else $error("spi_cmd_handler upload beat changed under back-pressure");

    a_start_issue: assert property (@(posedge clk) disable iff (!rst_n)
        o_spi_start |-> $past(state) == ST_ISSUE)
        else $error("spi_cmd_handler spi start outside issue");

endmodule

`default_nettype wire

/* hdl/spi_bridge_top.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_bridge_top (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            i_cmd_start,
    input  wire spi_bridge_pkg::cmd_type_t i_cmd_type,
    input  wire spi_bridge_pkg::cmd_len_t  i_cmd_length,
    input  wire                            i_cmd_data_valid,
    input  wire spi_bridge_pkg::cmd_beat_t i_cmd_beat,
    input  wire                            i_cmd_done,
    output logic                           o_cmd_ready,
    output logic                           o_upload_valid,
    output spi_bridge_pkg::upload_beat_t   o_upload_beat,
    input  wire                            i_upload_ready,
    output logic                           o_spi_clk,
    output logic                           o_spi_cs_n,
    output logic                           o_spi_mosi,
    input  wire                            i_spi_miso
);

    spi_bridge_pkg::spi_cfg_t cfg;
    spi_bridge_pkg::byte_t    spi_tx_byte;
    spi_bridge_pkg::byte_t    spi_rx_byte;
    logic                     spi_start;
    logic                     spi_done;

    spi_cmd_handler u_handler (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_cmd_start      (i_cmd_start),
        .i_cmd_type       (i_cmd_type),
        .i_cmd_length     (i_cmd_length),
        .i_cmd_data_valid (i_cmd_data_valid),
        .i_cmd_beat       (i_cmd_beat),
        .i_cmd_done       (i_cmd_done),
        .i_upload_ready   (i_upload_ready),
        .i_spi_rx_byte    (spi_rx_byte),
        .i_spi_done       (spi_done),
        .o_cmd_ready      (o_cmd_ready),
        .o_upload_valid   (o_upload_valid),
        .o_upload_beat    (o_upload_beat),
        .o_spi_start      (spi_start),
        .o_spi_tx_byte    (spi_tx_byte)
    );

    // listens to the same command stream, config type only
    spi_cfg_regs u_cfg (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_cmd_start      (i_cmd_start),
        .i_cmd_type       (i_cmd_type),
        .i_cmd_data_valid (i_cmd_data_valid),
        .i_cmd_beat       (i_cmd_beat),
        .i_cmd_done       (i_cmd_done),
        .o_cfg            (cfg)
    );

    spi_byte_master u_master (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_start    (spi_start),
        .i_tx_byte  (spi_tx_byte),
        .i_cfg      (cfg),
        .i_spi_miso (i_spi_miso),
        .o_rx_byte  (spi_rx_byte),
        .o_done     (spi_done),
        .o_busy     (),
        .o_spi_clk  (o_spi_clk),
        .o_spi_cs_n (o_spi_cs_n),
        .o_spi_mosi (o_spi_mosi)
    );

endmodule

`default_nettype wire

/* sim/spi_slave_model.sv */
`default_nettype none
`timescale 1ns/1ps

// mode 0 SPI slave, replies with the previous received byte XOR 0xa5
module spi_slave_model (
    input  wire        i_rst_n,
    input  wire        i_lsb_first,
    input  wire        i_spi_clk,
    input  wire        i_spi_cs_n,
    input  wire        i_spi_mosi,
    output logic       o_spi_miso,
    output logic [7:0] o_last_byte,
    output int         o_byte_count
);

    logic [7:0] rx_sr;
    logic [7:0] reply;
    logic [7:0] prev_byte;
    logic       cs_q;
    logic       clk_q;
    int         bit_n;

    function automatic logic reply_bit(input logic [7:0] value, input int n, input logic lsb);
        return lsb ? value[n] : value[7 - n];
    endfunction

    always @(i_rst_n or i_spi_cs_n or i_spi_clk) begin
        if (i_rst_n !== 1'b1) begin
            prev_byte    = 8'h00;  // first reply is 0xa5
            rx_sr        = 8'h00;
            bit_n        = 0;
            o_spi_miso   = 1'b0;
            o_last_byte  = 8'h00;
            o_byte_count = 0;
        end else if (i_spi_cs_n !== cs_q) begin
            if (i_spi_cs_n === 1'b0) begin
                reply      = prev_byte ^ 8'ha5;
                bit_n      = 0;
                rx_sr      = 8'h00;
                o_spi_miso = reply_bit(reply, 0, i_lsb_first);  // valid before first rise
            end else if (cs_q === 1'b0) begin
                o_last_byte  = rx_sr;
                prev_byte    = rx_sr;
                o_byte_count = o_byte_count + 1;
            end
        end else if (i_spi_cs_n === 1'b0 && i_spi_clk !== clk_q) begin
            if (i_spi_clk === 1'b1) begin
                rx_sr = i_lsb_first ? {i_spi_mosi, rx_sr[7:1]} : {rx_sr[6:0], i_spi_mosi};
            end else begin
                bit_n = bit_n + 1;
                if (bit_n < 8) o_spi_miso = reply_bit(reply, bit_n, i_lsb_first);
            end
        end
        cs_q  = i_spi_cs_n;
        clk_q = i_spi_clk;
    end

endmodule

`default_nettype wire

/* sim/tb_spi_bridge.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_spi_bridge;

    localparam int CYCLE_LIMIT = 20000;

    typedef spi_bridge_pkg::byte_t byte_q_t[$];

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         cmd_start;
    spi_bridge_pkg::cmd_type_t    cmd_type;
    spi_bridge_pkg::cmd_len_t     cmd_length;
    logic                         cmd_data_valid;
    spi_bridge_pkg::cmd_beat_t    cmd_beat;
    logic                         cmd_done;
    logic                         cmd_ready;
    logic                         upload_valid;
    spi_bridge_pkg::upload_beat_t upload_beat;
    logic                         upload_ready;
    logic                         spi_clk;
    logic                         spi_cs_n;
    logic                         spi_mosi;
    logic                         spi_miso;
    logic                         slave_lsb_first = 1'b0;
    logic [7:0]                   slave_last;
    int                           slave_count;
    int                           seen_count = 0;
    int                           cycle_cnt = 0;
    int                           exp_half = 2;       // reset half period
    int                           phase_run = 0;
    int                           cs_falls = 0;
    logic                         last_sclk = 1'b0;
    logic                         last_cs_n = 1'b1;
    logic                         ready_random = 1'b0;
    spi_bridge_pkg::byte_t        model_prev = 8'h00;  // slave's last byte
    spi_bridge_pkg::byte_t        exp_b;
    byte_q_t                      exp_mosi_q;
    byte_q_t                      exp_up_q;

    always #20 clk = ~clk;

    spi_bridge_top u_spi_bridge_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_cmd_start      (cmd_start),
        .i_cmd_type       (cmd_type),
        .i_cmd_length     (cmd_length),
        .i_cmd_data_valid (cmd_data_valid),
        .i_cmd_beat       (cmd_beat),
        .i_cmd_done       (cmd_done),
        .o_cmd_ready      (cmd_ready),
        .o_upload_valid   (upload_valid),
        .o_upload_beat    (upload_beat),
        .i_upload_ready   (upload_ready),
        .o_spi_clk        (spi_clk),
        .o_spi_cs_n       (spi_cs_n),
        .o_spi_mosi       (spi_mosi),
        .i_spi_miso       (spi_miso)
    );

    spi_slave_model u_slave (
        .i_rst_n      (rst_n),
        .i_lsb_first  (slave_lsb_first),
        .i_spi_clk    (spi_clk),
        .i_spi_cs_n   (spi_cs_n),
        .i_spi_mosi   (spi_mosi),
        .o_spi_miso   (spi_miso),
        .o_last_byte  (slave_last),
        .o_byte_count (slave_count)
    );

    task automatic value_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    a_idle_pins: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_ready |-> spi_cs_n && !spi_clk && !upload_valid)
        else value_error("SPI or upload activity while cmd_ready is high");
    a_sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        spi_cs_n |-> !spi_clk)
        else value_error("sclk high with cs_n deasserted");
    a_upload_source: assert property (@(posedge clk) disable iff (!rst_n)
        upload_valid |-> upload_beat.source == 8'h03)
        else value_error("upload source tag is not 0x03");
    a_upload_hold: assert property (@(posedge clk) disable iff (!rst_n)
        upload_valid && !upload_ready |=> upload_valid && $stable(upload_beat))
        else value_error("upload beat dropped or changed under back-pressure");

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    always @(posedge clk) begin
        #2;
        upload_ready = ready_random ? 1'($urandom % 2) : 1'b1;
    end

    // scoreboards for uploads and bytes seen by the slave
    always @(posedge clk) begin
        if (rst_n) begin
            if (upload_valid && upload_ready) begin
                if (exp_up_q.size() == 0) begin
                    value_error($sformatf("unexpected upload 0x%02h", upload_beat.data));
                end
                exp_b = exp_up_q.pop_front();
                assert (upload_beat.data == exp_b)
                    else value_error($sformatf("upload 0x%02h, expected 0x%02h",
                                               upload_beat.data, exp_b));
            end
            if (slave_count != seen_count) begin
                seen_count = slave_count;
                if (exp_mosi_q.size() == 0) begin
                    value_error($sformatf("unexpected SPI byte 0x%02h", slave_last));
                end
                exp_b = exp_mosi_q.pop_front();
                assert (slave_last == exp_b)
                    else value_error($sformatf("slave got 0x%02h, expected 0x%02h",
                                               slave_last, exp_b));
            end
        end
    end

    // sclk high and low phase lengths while selected
    always @(posedge clk) begin
        if (!rst_n) begin
            phase_run = 0;
        end else begin
            if (last_cs_n && !spi_cs_n) cs_falls++;
            if (spi_cs_n) begin
                if (!last_cs_n) begin  // last low half before cs_n rises
                    assert (phase_run == exp_half)
                        else value_error($sformatf("final sclk low of %0d cycles, expected %0d",
                                                   phase_run, exp_half));
                end
                phase_run = 0;
            end else if (spi_clk != last_sclk) begin
                assert (phase_run == exp_half)
                    else value_error($sformatf("sclk phase of %0d cycles, expected %0d",
                                               phase_run, exp_half));
                phase_run = 1;
            end else begin
                phase_run++;
            end
        end
        last_sclk = spi_clk;
        last_cs_n = spi_cs_n;
    end

    function automatic byte_q_t random_bytes(input int n);
        byte_q_t q;
        for (int i = 0; i < n; i++) q.push_back(spi_bridge_pkg::byte_t'($urandom % 256));
        return q;
    endfunction

    task automatic wait_ready();
        do begin
            @(posedge clk);
            #2;
        end while (cmd_ready !== 1'b1);
    endtask

    task automatic drive_cmd(input spi_bridge_pkg::cmd_type_t ctype,
                             input spi_bridge_pkg::cmd_len_t len, input byte_q_t payload);
        while (cmd_ready !== 1'b1) begin
            @(posedge clk);
            #2;
        end
        cmd_start  = 1'b1;
        cmd_type   = ctype;
        cmd_length = len;
        @(posedge clk);
        #2;
        cmd_start = 1'b0;
        for (int i = 0; i < payload.size(); i++) begin
            cmd_data_valid = 1'b1;
            cmd_beat       = '{data: payload[i], index: spi_bridge_pkg::cmd_len_t'(i)};
            @(posedge clk);
            #2;
        end
        cmd_data_valid = 1'b0;
        cmd_done       = 1'b1;
        @(posedge clk);
        #2;
        cmd_done = 1'b0;
    endtask

    task automatic run_xfer(input byte_q_t wr, input int rd_len);
        byte_q_t payload;
        payload = wr;
        payload.push_front(spi_bridge_pkg::byte_t'(rd_len));
        payload.push_front(spi_bridge_pkg::byte_t'(wr.size()));
        foreach (wr[i]) begin
            exp_mosi_q.push_back(wr[i]);
            model_prev = wr[i];
        end
        for (int i = 0; i < rd_len; i++) begin  // zeros go out while the replies come back
            exp_mosi_q.push_back(8'h00);
            exp_up_q.push_back(model_prev ^ 8'ha5);
            model_prev = 8'h00;
        end
        drive_cmd(8'h11, spi_bridge_pkg::cmd_len_t'(payload.size()), payload);
        assert (cmd_ready === 1'b0) else value_error("cmd_ready still high after done");
        wait_ready();
        @(posedge clk);
        #2;
        assert (exp_mosi_q.size() == 0 && exp_up_q.size() == 0)
            else value_error($sformatf("%0d SPI bytes and %0d uploads missing",
                                       exp_mosi_q.size(), exp_up_q.size()));
    endtask

    task automatic apply_config(input spi_bridge_pkg::byte_t half, input logic lsb);
        byte_q_t payload;
        payload.push_back(half);
        payload.push_back({7'd0, lsb});
        drive_cmd(8'h12, 16'd2, payload);
        assert (cmd_ready === 1'b1) else value_error("cmd_ready dropped for config");
        if (half != 8'd0) exp_half = half;  // zero keeps the old value
        slave_lsb_first = lsb;
    endtask

    task automatic check_ignored(input spi_bridge_pkg::cmd_type_t ctype, input int len);
        int falls_before;
        int count_before;
        falls_before = cs_falls;
        count_before = slave_count;
        drive_cmd(ctype, spi_bridge_pkg::cmd_len_t'(len), random_bytes(len));
        repeat (60) @(posedge clk);
        #2;
        assert (cs_falls == falls_before && slave_count == count_before && cmd_ready)
            else value_error($sformatf("command type 0x%02h length %0d was not ignored",
                                       ctype, len));
    endtask

    initial begin
        void'($urandom(3));
        rst_n          = 1'b0;
        cmd_start      = 1'b0;
        cmd_type       = '0;
        cmd_length     = '0;
        cmd_data_valid = 1'b0;
        cmd_beat       = '0;
        cmd_done       = 1'b0;
        upload_ready   = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        assert (spi_cs_n === 1'b1 && spi_clk === 1'b0 && upload_valid === 1'b0
                && cmd_ready === 1'b1)
            else value_error("outputs not idle after reset");

        run_xfer(random_bytes(4), 0);  // write only
        run_xfer(random_bytes(3), 4);
        run_xfer(random_bytes(0), 2);
        ready_random = 1'b1;
        run_xfer(random_bytes(2), 6);
        ready_random = 1'b0;

        apply_config(8'd3, 1'b1);
        run_xfer(random_bytes(3), 3);
        apply_config(8'd0, 1'b1);
        run_xfer(random_bytes(2), 2);

        check_ignored(8'h11, 1);
        check_ignored(8'h55, 4);
        run_xfer(random_bytes(1), 1);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hdl/spi_bridge_pkg.sv
hdl/spi_byte_master.sv
hdl/spi_cfg_regs.sv
hdl/spi_cmd_handler.sv
hdl/spi_bridge_top.sv
sim/spi_slave_model.sv
sim/tb_spi_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the SPI bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_spi_bridge -o tb_spi_bridge > build.log 2>&1 \
    && ./obj_dir/tb_spi_bridge > sim.log 2>&1
grep -q "^PASS: all tests$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
